// File: resource_manager.f
+incdir+sim
verilog/rm_pkg.sv
verilog/priority_encoder.sv
verilog/free_slot_allocator.sv
verilog/tag_sram.sv
verilog/plane_table.sv
verilog/list_controller.sv
verilog/resource_manager.sv
sim/tb_resource_manager.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the resource manager testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f resource_manager.f \
    --top-module tb_resource_manager -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_resource_manager > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0

// File: sim/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// One record of the model, kept in global arrival order
typedef struct packed {
    plane_id_t plane;
    host_id_t  host;
    meta_t     meta;
} model_rec_t;

model_rec_t model_q[$];

task automatic model_insert(input rm_cmd_t cmd, output rm_rsp_t exp);
    model_rec_t rec;
    exp = '{ok: 1'b0, meta: '0};
    if (model_q.size() < NUM_TAGS)
    begin
        rec = '{plane: cmd.plane, host: cmd.host, meta: cmd.meta};
        model_q.push_back(rec);
        exp = '{ok: 1'b1, meta: cmd.meta};
    end
endtask

// Oldest record of the plane with the requested host
task automatic model_pop(input rm_cmd_t cmd, output rm_rsp_t exp);
    int found;
    found = -1;
    exp   = '{ok: 1'b0, meta: '0};
    for (int i = 0; i < model_q.size(); i++)
    begin
        if (found < 0 && model_q[i].plane == cmd.plane && model_q[i].host == cmd.host)
            found = i;
    end
    if (found >= 0)
    begin
        exp = '{ok: 1'b1, meta: model_q[found].meta};
        model_q.delete(found);
    end
endtask

task automatic model_reset(output rm_rsp_t exp);
    model_q.delete();
    exp = '{ok: 1'b1, meta: '0};
endtask

`endif

// File: sim/tb_resource_manager.sv
module tb_resource_manager;

    import rm_pkg::*;

    localparam int NUM_PLANES    = 4;
    localparam int NUM_TAGS      = 16;
    localparam int DIRECTED_CMDS = 70;
    localparam int RANDOM_CMDS   = 2000;
    localparam int MAX_CYCLES    = (DIRECTED_CMDS + RANDOM_CMDS) * (2*NUM_TAGS + 8) + 16;

    logic    i_clk;
    logic    i_rst_n;
    logic    i_req;
    rm_cmd_t i_cmd;
    logic    o_ack;
    rm_rsp_t o_rsp;

    logic [31:0] lfsr_q = 32'h81182583;
    int          cycle_cnt = 0;
    logic        ack_prev = 1'b0;
    logic        req_prev = 1'b0;

    `include "tb_ref_model.svh"

    resource_manager
    #(
        .NUM_PLANES (NUM_PLANES),
        .NUM_TAGS   (NUM_TAGS)
    )
    dut_i
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (i_req),
        .i_cmd   (i_cmd),
        .o_ack   (o_ack),
        .o_rsp   (o_rsp)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Entered and left 1 time unit after a rising edge
    task automatic run_cmd(input string name, input rm_op_e op, input int plane,
                           input int host, input meta_t meta);
        rm_cmd_t cmd;
        rm_rsp_t exp;
        cmd.op    = op;
        cmd.plane = plane_id_t'(plane);
        cmd.host  = host_id_t'(host);
        cmd.meta  = meta;
        case (op)
            OP_INSERT: model_insert(cmd, exp);
            OP_POP:    model_pop(cmd, exp);
            default:   model_reset(exp);
        endcase
        i_cmd = cmd;
        i_req = 1'b1;
        do
        begin
            @(posedge i_clk);
            #1;
        end
        while (!o_ack);
        assert (o_rsp.ok == exp.ok && (!exp.ok || o_rsp.meta == exp.meta))
        else
            fail_run($sformatf("mismatch %s expected ok=%0b meta=%h actual ok=%0b meta=%h",
                               name, exp.ok, exp.meta, o_rsp.ok, o_rsp.meta));
        i_req = 1'b0;
        do
        begin
            @(posedge i_clk);
            #1;
        end
        while (o_ack);
    endtask

    always @(posedge i_clk)
    begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES)
            fail_run($sformatf("timeout: the run did not finish within %0d cycles", MAX_CYCLES));
    end

    // Request level of the cycle before the edge where ack rose
    always @(negedge i_clk)
    begin
        if (i_rst_n)
            assert (!(o_ack && !ack_prev && !req_prev))
            else
                fail_run("handshake error: o_ack rose while i_req was low");
        ack_prev = o_ack;
        req_prev = i_req;
    end

    initial
    begin
        int          hosts[6];
        logic [31:0] rnd;
        rm_op_e      op;
        hosts   = '{1, 2, 1, 3, 2, 1};
        i_rst_n = 1'b0;
        i_req   = 1'b0;
        i_cmd   = '0;
        repeat (4) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;

        assert (!o_ack)
        else
            fail_run("o_ack is high right after reset");
        for (int p = 0; p < NUM_PLANES; p++)
            run_cmd("empty_after_reset", OP_POP, p, 0, '0);

        for (int i = 0; i < 5; i++)
            run_cmd("fifo_order", OP_INSERT, 0, 2, meta_t'(16'h1000 + i));
        for (int i = 0; i < 6; i++)
            run_cmd("fifo_order", OP_POP, 0, 2, '0);

        for (int i = 0; i < 6; i++)
            run_cmd("mixed_hosts", OP_INSERT, 1, hosts[i], meta_t'(16'h2000 + i));
        run_cmd("mixed_hosts", OP_POP, 1, 2, '0);   // Middle record
        run_cmd("mixed_hosts", OP_POP, 1, 1, '0);   // Head record
        run_cmd("mixed_hosts", OP_POP, 1, 1, '0);
        run_cmd("mixed_hosts", OP_POP, 1, 1, '0);   // Tail record
        run_cmd("mixed_hosts", OP_INSERT, 1, 1, 16'h2006);
        run_cmd("mixed_hosts", OP_POP, 1, 3, '0);
        run_cmd("mixed_hosts", OP_POP, 1, 1, '0);
        run_cmd("mixed_hosts", OP_POP, 1, 2, '0);
        run_cmd("mixed_hosts", OP_POP, 1, 1, '0);

        for (int i = 0; i < NUM_TAGS; i++)
            run_cmd("tags_full", OP_INSERT, i % NUM_PLANES, i % 4, meta_t'(16'h4000 + i));
        run_cmd("tags_full", OP_INSERT, 3, 1, 16'h4fff);
        run_cmd("tags_full", OP_POP, 2, 2, '0);
        run_cmd("tags_full", OP_INSERT, 2, 2, 16'h4eee);

        run_cmd("reset_cmd", OP_RESET, 0, 0, '0);
        for (int p = 0; p < NUM_PLANES; p++)
            run_cmd("reset_cmd", OP_POP, p, p, '0);
        for (int i = 0; i < NUM_TAGS; i++)
            run_cmd("reset_cmd", OP_INSERT, i % NUM_PLANES, 3, meta_t'(16'h5000 + i));

        for (int i = 0; i < RANDOM_CMDS; i++)
        begin
            rnd = draw_bits(5);
            if (rnd[4:0] < 5'd19)
                op = OP_INSERT;
            else if (rnd[4:0] < 5'd31)
                op = OP_POP;
            else
                op = OP_RESET;
            rnd = draw_bits(2);
            run_cmd("random_run", op, int'(rnd[1:0]), int'(draw_bits(2)), meta_t'(draw_bits(16)));
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// File: verilog/free_slot_allocator.sv
module free_slot_allocator
#(
    parameter int NUM_TAGS = 32
)
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_alloc,
    input  logic              i_release,
    input  rm_pkg::tag_addr_t i_release_addr,
    input  logic              i_clear,
    output rm_pkg::tag_addr_t o_free_tag,
    output logic              o_full
);

    localparam int IW = $clog2(NUM_TAGS);

    logic [NUM_TAGS-1:0] used_q;
    logic                any_free;

    priority_encoder
    #(
        .NUM_TAGS (NUM_TAGS)
    )
    free_enc_i
    (
        .i_vec   (~used_q),
        .o_index (o_free_tag),
        .o_any   (any_free)
    );

    assign o_full = !any_free;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            used_q <= '0;
        else if (i_clear)
            used_q <= '0;   // All tags free
        else
        begin
            if (i_alloc)
                used_q[o_free_tag[IW-1:0]] <= 1'b1;
            if (i_release)
                used_q[i_release_addr[IW-1:0]] <= 1'b0;
        end
    end

    // Controller must check full before taking a tag
    assert property (@(posedge i_clk) disable iff (!i_rst_n) i_alloc |-> !o_full);

    // Double free means a list lost track of a record
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_release |-> used_q[i_release_addr[IW-1:0]]);

endmodule

// File: verilog/list_controller.sv
module list_controller
#(
    parameter int NUM_PLANES = 8
)
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_req,
    input  rm_pkg::rm_cmd_t    i_cmd,
    output logic               o_ack,
    output rm_pkg::rm_rsp_t    o_rsp,
    output logic               o_alloc,
    output logic               o_release,
    output rm_pkg::tag_addr_t  o_release_addr,
    output logic               o_alloc_clear,
    input  rm_pkg::tag_addr_t  i_free_tag,
    input  logic               i_full,
    output logic               o_rd_en,
    output rm_pkg::tag_addr_t  o_rd_addr,
    input  rm_pkg::tag_entry_t i_rd_data,
    output logic               o_wr_en,
    output rm_pkg::tag_addr_t  o_wr_addr,
    output rm_pkg::tag_entry_t o_wr_data,
    output rm_pkg::plane_id_t  o_plane,
    input  rm_pkg::tag_addr_t  i_head,
    input  rm_pkg::tag_addr_t  i_tail,
    input  logic               i_valid,
    output logic               o_set_head,
    output rm_pkg::tag_addr_t  o_head_addr,
    output logic               o_set_tail,
    output rm_pkg::tag_addr_t  o_tail_addr,
    output logic               o_set_empty,
    output logic               o_plane_clear
);

    import rm_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    tag_addr_t   new_tag_q;
    tag_addr_t   cur_addr_q;
    tag_addr_t   prev_addr_q;
    tag_entry_t  cur_entry_q;
    tag_entry_t  prev_entry_q;
    logic        match_q;
    rm_rsp_t     rsp_q;
    logic        plane_ok;
    logic        at_head;
    logic        at_tail;

    assign plane_ok = int'(i_cmd.plane) < NUM_PLANES;
    assign at_head  = cur_addr_q == i_head;
    assign at_tail  = cur_addr_q == i_tail;
    assign o_plane  = i_cmd.plane;   // Command held stable until ack
    assign o_ack    = state_q == ST_ACK_WAIT;
    assign o_rsp    = rsp_q;

    always_comb
    begin
        state_d        = state_q;
        o_alloc        = 1'b0;
        o_release      = 1'b0;
        o_release_addr = cur_addr_q;
        o_alloc_clear  = 1'b0;
        o_rd_en        = 1'b0;
        o_rd_addr      = cur_addr_q;
        o_wr_en        = 1'b0;
        o_wr_addr      = i_free_tag;
        o_wr_data      = '{host: i_cmd.host, meta: i_cmd.meta, next: '0};  // Tail next unused
        o_set_head     = 1'b0;
        o_head_addr    = i_free_tag;
        o_set_tail     = 1'b0;
        o_tail_addr    = i_free_tag;
        o_set_empty    = 1'b0;
        o_plane_clear  = 1'b0;

        case (state_q)
            ST_IDLE:
            begin
                if (i_req)
                begin
                    case (i_cmd.op)
                        OP_RESET:  state_d = ST_RESET;
                        OP_INSERT:
                        begin
                            if (i_full || !plane_ok)
                                state_d = ST_DONE;
                            else if (i_valid)
                                state_d = ST_TAIL_READ;
                            else
                                state_d = ST_INS_WRITE;
                        end
                        OP_POP:    state_d = (plane_ok && i_valid) ? ST_POP_READ : ST_DONE;
                        default:   state_d = ST_DONE;
                    endcase
                end
            end
            ST_RESET:
            begin
                o_alloc_clear = 1'b1;
                o_plane_clear = 1'b1;
                state_d       = ST_ACK_WAIT;
            end
            ST_INS_WRITE:
            begin
                o_wr_en    = 1'b1;
                o_alloc    = 1'b1;
                o_set_head = 1'b1;
                o_set_tail = 1'b1;
                state_d    = ST_ACK_WAIT;
            end
            ST_TAIL_READ:
            begin
                // New entry goes in while the old tail is fetched
                o_wr_en   = 1'b1;
                o_alloc   = 1'b1;
                o_rd_en   = 1'b1;
                o_rd_addr = i_tail;
                state_d   = ST_TAIL_PATCH;
            end
            ST_TAIL_PATCH:
            begin
                o_wr_en     = 1'b1;
                o_wr_addr   = i_tail;
                o_wr_data   = '{host: i_rd_data.host, meta: i_rd_data.meta, next: new_tag_q};
                o_set_tail  = 1'b1;
                o_tail_addr = new_tag_q;
                state_d     = ST_ACK_WAIT;
            end
            ST_POP_READ:
            begin
                o_rd_en = 1'b1;   // Head record
                state_d = ST_POP_WAIT;
            end
            ST_POP_WAIT: state_d = ST_POP_CHECK;
            ST_POP_CHECK:
            begin
                if (match_q)
                    state_d = ST_UNLINK;
                else if (at_tail)
                    state_d = ST_DONE;   // Walked the whole list
                else
                begin
                    o_rd_en   = 1'b1;
                    o_rd_addr = cur_entry_q.next;
                    state_d   = ST_POP_WAIT;
                end
            end
            ST_UNLINK:
            begin
                o_release = 1'b1;
                if (at_head && at_tail)
                    o_set_empty = 1'b1;
                else if (at_head)
                begin
                    o_set_head  = 1'b1;
                    o_head_addr = cur_entry_q.next;
                end
                else if (at_tail)
                begin
                    o_set_tail  = 1'b1;
                    o_tail_addr = prev_addr_q;
                end
                else
                begin
                    // Bypass the popped record
                    o_wr_en   = 1'b1;
                    o_wr_addr = prev_addr_q;
                    o_wr_data = '{host: prev_entry_q.host, meta: prev_entry_q.meta,
                                  next: cur_entry_q.next};
                end
                state_d = ST_ACK_WAIT;
            end
            ST_DONE:     state_d = ST_ACK_WAIT;
            ST_ACK_WAIT:
            begin
                if (!i_req)
                    state_d = ST_IDLE;
            end
            default:     state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge i_clk)
    begin
        case (state_q)
            ST_IDLE:       cur_addr_q <= i_head;
            ST_RESET:      rsp_q <= '{ok: 1'b1, meta: '0};
            ST_INS_WRITE:  rsp_q <= '{ok: 1'b1, meta: i_cmd.meta};
            ST_TAIL_READ:
            begin
                new_tag_q <= i_free_tag;
                rsp_q     <= '{ok: 1'b1, meta: i_cmd.meta};
            end
            ST_POP_WAIT:
            begin
                cur_entry_q <= i_rd_data;
                match_q     <= i_rd_data.host == i_cmd.host;
            end
            ST_POP_CHECK:
            begin
                if (!match_q && !at_tail)
                begin
                    prev_addr_q  <= cur_addr_q;
                    prev_entry_q <= cur_entry_q;
                    cur_addr_q   <= cur_entry_q.next;
                end
            end
            ST_UNLINK:     rsp_q <= '{ok: 1'b1, meta: cur_entry_q.meta};
            ST_DONE:       rsp_q <= '{ok: 1'b0, meta: '0};
            default:       ;
        endcase
    end

    // Ack only answers a pending request
    assert property (@(posedge i_clk) disable iff (!i_rst_n) $rose(o_ack) |-> $past(i_req));

    // Registered read would miss a same-cycle write to the same tag
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_rd_en && o_wr_en && (o_rd_addr == o_wr_addr)));

endmodule

// File: verilog/plane_table.sv
module plane_table
#(
    parameter int NUM_PLANES = 8
)
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  rm_pkg::plane_id_t i_plane,
    output rm_pkg::tag_addr_t o_head,
    output rm_pkg::tag_addr_t o_tail,
    output logic              o_valid,
    input  logic              i_set_head,
    input  rm_pkg::tag_addr_t i_head_addr,
    input  logic              i_set_tail,
    input  rm_pkg::tag_addr_t i_tail_addr,
    input  logic              i_set_empty,
    input  logic              i_clear
);

    import rm_pkg::*;

    localparam int PW = (NUM_PLANES > 1) ? $clog2(NUM_PLANES) : 1;

    logic [PW-1:0]         sel;
    tag_addr_t             head_q [NUM_PLANES];
    tag_addr_t             tail_q [NUM_PLANES];
    logic [NUM_PLANES-1:0] valid_q;

    assign sel     = i_plane[PW-1:0];
    assign o_head  = head_q[sel];
    assign o_tail  = tail_q[sel];
    assign o_valid = valid_q[sel];

    always_ff @(posedge i_clk)
    begin
        if (i_set_head)
            head_q[sel] <= i_head_addr;
        if (i_set_tail)
            tail_q[sel] <= i_tail_addr;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            valid_q <= '0;
        else if (i_clear)
            valid_q <= '0;
        else if (i_set_empty)
            valid_q[sel] <= 1'b0;
        else if (i_set_head && i_set_tail)
            valid_q[sel] <= 1'b1;   // First record of the plane
    end

    // Emptying and relinking the head are exclusive unlink cases
    assert property (@(posedge i_clk) disable iff (!i_rst_n) !(i_set_empty && i_set_head));

endmodule

// File: verilog/priority_encoder.sv
module priority_encoder
#(
    parameter int NUM_TAGS = 32
)
(
    input  logic [NUM_TAGS-1:0] i_vec,
    output rm_pkg::tag_addr_t   o_index,
    output logic                o_any
);

    import rm_pkg::*;

    localparam int LVLS = $clog2(NUM_TAGS);

    // Each level halves the node count and grows the winner prefix by one bit
    genvar l;
    genvar n;
    generate
        for (l = 0; l < LVLS; l++)
        begin : g_lvl
            localparam int NODES = NUM_TAGS >> (l + 1);
            logic [NODES-1:0]      valid;
            logic [NODES-1:0][l:0] win;
            for (n = 0; n < NODES; n++)
            begin : g_node
                if (l == 0)
                begin : g_leaf
                    assign valid[n] = i_vec[2*n] | i_vec[2*n+1];
                    assign win[n]   = !i_vec[2*n];   // Lower bit wins
                end
                else
                begin : g_inner
                    assign valid[n] = g_lvl[l-1].valid[2*n] | g_lvl[l-1].valid[2*n+1];
                    assign win[n]   = g_lvl[l-1].valid[2*n] ? {1'b0, g_lvl[l-1].win[2*n]}
                                                            : {1'b1, g_lvl[l-1].win[2*n+1]};
                end
            end
        end
    endgenerate

    assign o_any   = g_lvl[LVLS-1].valid[0];
    assign o_index = tag_addr_t'(g_lvl[LVLS-1].win[0]);

endmodule

// File: verilog/resource_manager.sv
module resource_manager
#(
    parameter int NUM_PLANES = 8,
    parameter int NUM_TAGS   = 32
)
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_req,
    input  rm_pkg::rm_cmd_t i_cmd,
    output logic            o_ack,
    output rm_pkg::rm_rsp_t o_rsp
);

    import rm_pkg::*;

    logic       alloc;
    logic       release_tag;
    tag_addr_t  release_addr;
    logic       alloc_clear;
    tag_addr_t  free_tag;
    logic       full;
    logic       rd_en;
    tag_addr_t  rd_addr;
    tag_entry_t rd_data;
    logic       wr_en;
    tag_addr_t  wr_addr;
    tag_entry_t wr_data;
    plane_id_t  plane;
    tag_addr_t  head;
    tag_addr_t  tail;
    logic       plane_valid;
    logic       set_head;
    tag_addr_t  head_addr;
    logic       set_tail;
    tag_addr_t  tail_addr;
    logic       set_empty;
    logic       plane_clear;

    list_controller
    #(
        .NUM_PLANES (NUM_PLANES)
    )
    ctrl_i
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_req          (i_req),
        .i_cmd          (i_cmd),
        .o_ack          (o_ack),
        .o_rsp          (o_rsp),
        .o_alloc        (alloc),
        .o_release      (release_tag),
        .o_release_addr (release_addr),
        .o_alloc_clear  (alloc_clear),
        .i_free_tag     (free_tag),
        .i_full         (full),
        .o_rd_en        (rd_en),
        .o_rd_addr      (rd_addr),
        .i_rd_data      (rd_data),
        .o_wr_en        (wr_en),
        .o_wr_addr      (wr_addr),
        .o_wr_data      (wr_data),
        .o_plane        (plane),
        .i_head         (head),
        .i_tail         (tail),
        .i_valid        (plane_valid),
        .o_set_head     (set_head),
        .o_head_addr    (head_addr),
        .o_set_tail     (set_tail),
        .o_tail_addr    (tail_addr),
        .o_set_empty    (set_empty),
        .o_plane_clear  (plane_clear)
    );

    free_slot_allocator
    #(
        .NUM_TAGS (NUM_TAGS)
    )
    alloc_i
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_alloc        (alloc),
        .i_release      (release_tag),
        .i_release_addr (release_addr),
        .i_clear        (alloc_clear),
        .o_free_tag     (free_tag),
        .o_full         (full)
    );

    tag_sram
    #(
        .NUM_TAGS (NUM_TAGS)
    )
    sram_i
    (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rd_en   (rd_en),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data)
    );

    plane_table
    #(
        .NUM_PLANES (NUM_PLANES)
    )
    planes_i
    (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_plane     (plane),
        .o_head      (head),
        .o_tail      (tail),
        .o_valid     (plane_valid),
        .i_set_head  (set_head),
        .i_head_addr (head_addr),
        .i_set_tail  (set_tail),
        .i_tail_addr (tail_addr),
        .i_set_empty (set_empty),
        .i_clear     (plane_clear)
    );

endmodule

// File: verilog/rm_pkg.sv
package rm_pkg;

    localparam int HOST_W  = 4;
    localparam int PLANE_W = 3;
    localparam int TAG_W   = 5;
    localparam int META_W  = 16;

    typedef logic [HOST_W-1:0]  host_id_t;
    typedef logic [PLANE_W-1:0] plane_id_t;
    typedef logic [TAG_W-1:0]   tag_addr_t;   // Up to 32 tags
    typedef logic [META_W-1:0]  meta_t;

    typedef enum logic [1:0] {
        OP_INSERT = 2'd0,
        OP_POP    = 2'd1,
        OP_RESET  = 2'd2
    } rm_op_e;

    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,
        ST_RESET      = 4'd1,
        ST_INS_WRITE  = 4'd2,
        ST_TAIL_READ  = 4'd3,
        ST_TAIL_PATCH = 4'd4,
        ST_POP_READ   = 4'd5,
        ST_POP_WAIT   = 4'd6,
        ST_POP_CHECK  = 4'd7,
        ST_UNLINK     = 4'd8,
        ST_DONE       = 4'd9,
        ST_ACK_WAIT   = 4'd10
    } ctrl_state_e;

    typedef struct packed {
        rm_op_e    op;
        plane_id_t plane;
        host_id_t  host;
        meta_t     meta;
    } rm_cmd_t;

    // ok is insert accepted or pop found
    typedef struct packed {
        logic  ok;
        meta_t meta;
    } rm_rsp_t;

    typedef struct packed {
        host_id_t  host;
        meta_t     meta;
        tag_addr_t next;
    } tag_entry_t;

endpackage

// File: verilog/tag_sram.sv
module tag_sram
#(
    parameter int NUM_TAGS = 32
)
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_rd_en,
    input  rm_pkg::tag_addr_t  i_rd_addr,
    output rm_pkg::tag_entry_t o_rd_data,
    input  logic               i_wr_en,
    input  rm_pkg::tag_addr_t  i_wr_addr,
    input  rm_pkg::tag_entry_t i_wr_data
);

    import rm_pkg::*;

    localparam int AW = $clog2(NUM_TAGS);

    tag_entry_t mem [NUM_TAGS];

    always_ff @(posedge i_clk)
    begin
        if (i_wr_en)
            mem[i_wr_addr[AW-1:0]] <= i_wr_data;
    end

    // Same-address write in the read cycle returns old data
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_rd_data <= '0;
        else if (i_rd_en)
            o_rd_data <= mem[i_rd_addr[AW-1:0]];
    end

endmodule
